//--- hdl/alu_isa_pkg.sv
package alu_isa_pkg;

    // operand and result width.
    localparam int data_width = 32;

    // load immediate, one half of a word.
    localparam int imm_width = 16;

    // sequence tag, wraps modulo 16.
    localparam int tag_width = 4;

    typedef logic [data_width-1:0] data_t;
    typedef logic [imm_width-1:0]  imm_t;
    typedef logic [tag_width-1:0]  tag_t;

    // encodings follow the original instruction numbers.
    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_shl   = 4'd2,
        op_shr   = 4'd3,
        op_pass  = 4'd4,
        op_ldlo  = 4'd5,
        op_ldhi  = 4'd6,
        op_cmpeq = 4'd8,
        op_cmplt = 4'd9,
        op_cmpgt = 4'd10
    } alu_op_e;

endpackage

//--- hdl/alu_stream_pkg.sv
package alu_stream_pkg;

    import alu_isa_pkg::*;

    // one request as presented at the input.
    typedef struct packed {
        alu_op_e op;
        data_t   a;
        data_t   b;
        imm_t    imm;
    } alu_req_t;

    // request after the dispatcher has stamped it.
    typedef struct packed {
        tag_t     tag;
        alu_req_t req;
    } alu_treq_t;

    // flag is only set by the compares.
    typedef struct packed {
        tag_t  tag;
        data_t value;
        logic  flag;
    } alu_res_t;

endpackage

//--- hdl/alu_dispatch.sv
`timescale 1ns/1ps

module alu_dispatch
    import alu_isa_pkg::*;
    import alu_stream_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  alu_req_t             in_req,
    output logic [NUM_LANES-1:0] lane_valid,
    output alu_treq_t            lane_req [NUM_LANES]
);

    localparam int ptr_width = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [ptr_width-1:0] ptr_q;
    tag_t                 tag_q;
    logic [NUM_LANES-1:0] lane_sel;

    // decode the pointer to a lane select.
    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
        begin
            lane_sel[i] = in_valid && (ptr_q == ptr_width'(i));
        end
    end

    // pointer and tag advance on every accepted request.
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            ptr_q      <= '0;
            tag_q      <= '0;
            lane_valid <= '0;
        end
        else
        begin
            lane_valid <= lane_sel;
            if (in_valid)
            begin
                tag_q <= tag_q + 1'b1;
                if (ptr_q == ptr_width'(NUM_LANES - 1))
                    ptr_q <= '0;
                else
                    ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (lane_sel[i])
            begin
                lane_req[i].tag <= tag_q;
                lane_req[i].req <= in_req;
            end
        end
    end

endmodule

//--- hdl/alu_lane.sv
`timescale 1ns/1ps

module alu_lane
    import alu_isa_pkg::*;
    import alu_stream_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      req_valid,
    input  alu_treq_t req,
    output logic      res_valid,
    output alu_res_t  res
);

    data_t   op_a;
    data_t   op_b;
    imm_t    imm;
    alu_op_e op;

    data_t add_res;
    data_t sub_res;
    data_t shl_res;
    data_t shr_res;
    data_t ldlo_res;
    data_t ldhi_res;

    logic cmp_eq;
    logic cmp_lt;
    logic cmp_gt;

    data_t value_d;
    logic  flag_d;

    assign op     = req.req.op;
    assign op_a   = req.req.a;
    assign op_b   = req.req.b;
    assign imm    = req.req.imm;

    assign add_res = op_a + op_b;
    assign sub_res = op_a - op_b;

    // invert, shift, invert back so vacated bits come in as ones.
    // amounts of 32 or more leave all ones.
    assign shl_res = ~((~op_a) << op_b);
    assign shr_res = ~((~op_a) >> op_b);

    // half-word merges with the immediate.
    assign ldlo_res = {op_a[data_width-1:imm_width], imm};
    assign ldhi_res = {imm, op_a[imm_width-1:0]};

    // unsigned relations.
    assign cmp_eq = (op_a == op_b);
    assign cmp_lt = (op_a < op_b);
    assign cmp_gt = (op_a > op_b);

    always_comb
    begin
        value_d = '0;
        flag_d  = 1'b0;
        case (op)
            op_add:
                value_d = add_res;
            op_sub:
                value_d = sub_res;
            op_shl:
                value_d = shl_res;
            op_shr:
                value_d = shr_res;
            op_pass:
                value_d = op_a;
            op_ldlo:
                value_d = ldlo_res;
            op_ldhi:
                value_d = ldhi_res;
            op_cmpeq:
                flag_d = cmp_eq;
            op_cmplt:
                flag_d = cmp_lt;
            op_cmpgt:
                flag_d = cmp_gt;
            default:
            begin
                value_d = '0;
                flag_d  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            res_valid <= 1'b0;
        else
            res_valid <= req_valid;
    end

    // result payload, held between requests.
    always_ff @(posedge clock)
    begin
        if (req_valid)
        begin
            res.tag   <= req.tag;
            res.value <= value_d;
            res.flag  <= flag_d;
        end
    end

endmodule

//--- hdl/alu_collect.sv
`timescale 1ns/1ps

module alu_collect
    import alu_stream_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic [NUM_LANES-1:0] lane_valid,
    input  alu_res_t             lane_res [NUM_LANES],
    output logic                 out_valid,
    output alu_res_t             out_res
);

    logic     any_valid;
    alu_res_t sel_res;

    assign any_valid = |lane_valid;

    // lowest lane wins; only one is ever valid anyway.
    always_comb
    begin
        sel_res = lane_res[0];
        for (int i = NUM_LANES - 1; i >= 0; i--)
        begin
            if (lane_valid[i])
                sel_res = lane_res[i];
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= any_valid;
    end

    always_ff @(posedge clock)
    begin
        if (any_valid)
            out_res <= sel_res;
    end

endmodule

//--- hdl/alu_array_top.sv
`timescale 1ns/1ps

module alu_array_top
    import alu_stream_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     in_valid,
    input  alu_req_t in_req,
    output logic     out_valid,
    output alu_res_t out_res
);

    logic [NUM_LANES-1:0] lane_valid;
    alu_treq_t            lane_req [NUM_LANES];
    logic [NUM_LANES-1:0] res_valid;
    alu_res_t             lane_res [NUM_LANES];

    alu_dispatch #(
        .NUM_LANES (NUM_LANES)
    ) u_dispatch (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .lane_valid (lane_valid),
        .lane_req   (lane_req)
    );

    // one lane per round-robin slot.
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        alu_lane u_lane (
            .clock     (clock),
            .rst_n     (rst_n),
            .req_valid (lane_valid[i]),
            .req       (lane_req[i]),
            .res_valid (res_valid[i]),
            .res       (lane_res[i])
        );
    end

    alu_collect #(
        .NUM_LANES (NUM_LANES)
    ) u_collect (
        .clock      (clock),
        .rst_n      (rst_n),
        .lane_valid (res_valid),
        .lane_res   (lane_res),
        .out_valid  (out_valid),
        .out_res    (out_res)
    );

endmodule

//--- testbench/alu_array_assertions.sv
`timescale 1ns/1ps

module alu_array_assertions #(
    parameter int NUM_LANES = 4
) (
    input logic                 clock,
    input logic                 rst_n,
    input logic                 in_valid,
    input logic                 out_valid,
    input logic [NUM_LANES-1:0] lane_valid
);

    // fixed three cycle latency, both ways.
    property p_latency;
        @(posedge clock) disable iff (!rst_n)
            in_valid |-> ##3 out_valid;
    endproperty

    property p_no_spurious;
        @(posedge clock) disable iff (!rst_n)
            out_valid |-> $past(in_valid, 3);
    endproperty

    property p_reset_low;
        @(posedge clock) !rst_n |=> !out_valid;
    endproperty

    property p_lane_onehot;
        @(posedge clock) disable iff (!rst_n)
            $onehot0(lane_valid);
    endproperty

    a_latency:     assert property (p_latency)     else $error("out_valid missing 3 cycles after in_valid");
    a_no_spurious: assert property (p_no_spurious) else $error("out_valid without a request");
    a_reset_low:   assert property (p_reset_low)   else $error("out_valid high in reset");
    a_lane_onehot: assert property (p_lane_onehot) else $error("more than one lane strobed");

endmodule

bind alu_array_top alu_array_assertions #(
    .NUM_LANES (NUM_LANES)
) u_assertions (
    .clock      (clock),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .lane_valid (lane_valid)
);

//--- testbench/alu_array_tb.sv
`timescale 1ns/1ps

module alu_array_tb
    import alu_isa_pkg::*;
    import alu_stream_pkg::*;
();

    localparam int num_lanes    = 4;
    localparam int num_tests    = 400;
    localparam int reset_cycles = 4;
    localparam int clk_period   = 100;

    // one expected result and the cycle it must appear in.
    typedef struct packed {
        int       due;
        alu_res_t res;
    } expect_t;

    logic     clock;
    logic     rst_n;
    logic     in_valid;
    alu_req_t in_req;
    logic     out_valid;
    alu_res_t out_res;

    integer  seed = 32'h23bbd9a3;
    int      cycle = 0;
    int      error_count = 0;
    int      result_count = 0;
    tag_t    next_tag = '0;
    expect_t expect_q [$];

    alu_op_e op_list [10] = '{op_add, op_sub, op_shl, op_shr, op_pass,
                              op_ldlo, op_ldhi, op_cmpeq, op_cmplt, op_cmpgt};

    alu_array_top #(
        .NUM_LANES (num_lanes)
    ) uut (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

    initial
    begin
        clock = 1'b0;
        forever
            #(clk_period / 2) clock = ~clock;
    end

    always @(posedge clock)
        cycle <= cycle + 1;

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t ns: %s mismatch, got %0h expected %0h",
                     $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // expected result built from the opcode rules.
    function automatic alu_res_t model_result(input alu_req_t r, input tag_t tag);
        alu_res_t res;
        res.tag   = tag;
        res.value = '0;
        res.flag  = 1'b0;
        case (r.op)
            op_add:
                res.value = r.a + r.b;
            op_sub:
                res.value = r.a - r.b;
            op_shl:
            begin
                if (r.b >= 32)
                    res.value = '1;
                else
                    res.value = (r.a << r.b) | ((32'h1 << r.b) - 32'h1);
            end
            op_shr:
            begin
                if (r.b >= 32)
                    res.value = '1;
                else
                    res.value = (r.a >> r.b) | ~(32'hffff_ffff >> r.b);
            end
            op_pass:
                res.value = r.a;
            op_ldlo:
                res.value = {r.a[31:16], r.imm};
            op_ldhi:
                res.value = {r.imm, r.a[15:0]};
            op_cmpeq:
                res.flag = (r.a == r.b);
            op_cmplt:
                res.flag = (r.a < r.b);
            op_cmpgt:
                res.flag = (r.a > r.b);
            default:
                res.value = '0;
        endcase
        return res;
    endfunction

    task automatic drive_random();
        alu_req_t req;
        expect_t  ent;
        bit       coin;
        in_valid = (($unsigned($random(seed)) % 100) < 70);
        req.op   = op_list[$unsigned($random(seed)) % 10];
        req.a    = $random(seed);
        req.b    = $random(seed);
        req.imm  = $random(seed);
        coin     = $random(seed);
        // keep some shifts in range, and make some compares equal.
        if (coin && (req.op == op_shl || req.op == op_shr))
            req.b = {27'd0, req.b[4:0]};
        if (coin && (req.op == op_cmpeq || req.op == op_cmplt || req.op == op_cmpgt))
            req.b = req.a;
        in_req = req;
        if (in_valid)
        begin
            ent.due = cycle + 3;
            ent.res = model_result(req, next_tag);
            expect_q.push_back(ent);
            next_tag = next_tag + 1'b1;
        end
    endtask

    // outputs are looked at mid-cycle away from the edges.
    always @(negedge clock)
    begin
        expect_t ent;
        if (cycle > 0)
        begin
            if (expect_q.size() > 0 && expect_q[0].due == cycle)
            begin
                ent = expect_q.pop_front();
                check_value("out_valid", out_valid, 1);
                check_value("tag", out_res.tag, ent.res.tag);
                check_value("value", out_res.value, ent.res.value);
                check_value("flag", out_res.flag, ent.res.flag);
                result_count++;
            end
            else
            begin
                check_value("idle out_valid", out_valid, 0);
            end
        end
    end

    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < num_tests; n++)
        begin
            @(posedge clock);
            #1;
            drive_random();
        end
        @(posedge clock);
        #1;
        in_valid = 1'b0;
        in_req   = '0;
        while (expect_q.size() != 0)
            @(posedge clock);
        repeat (3) @(posedge clock);
        $display("%0d results checked", result_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial
    begin
        #((num_tests + reset_cycles + 50) * clk_period);
        $display("watchdog expired: the test did not finish in the expected time");
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule

//--- list.f
hdl/alu_isa_pkg.sv
hdl/alu_stream_pkg.sv
hdl/alu_dispatch.sv
hdl/alu_lane.sv
hdl/alu_collect.sv
hdl/alu_array_top.sv
testbench/alu_array_assertions.sv
testbench/alu_array_tb.sv

//--- Bender.yml
package:
  name: alu_array

sources:
  - hdl/alu_isa_pkg.sv
  - hdl/alu_stream_pkg.sv
  - hdl/alu_dispatch.sv
  - hdl/alu_lane.sv
  - hdl/alu_collect.sv
  - hdl/alu_array_top.sv
  - target: simulation
    files:
      - testbench/alu_array_assertions.sv
      - testbench/alu_array_tb.sv
